//--- Makefile
# Verilator build and run of the packet capture and replay testbench

TOP = tb_pcap_replay

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)
	verilator --lint-only --timing -f build.f --top-module pcap_replay_uengine

clean:
	rm -rf obj_dir

//--- build.f
design/mem_geom_pkg.sv
design/stream_pkg.sv
design/capture_writer.sv
design/capture_memory.sv
design/replay_sequencer.sv
design/replay_out_buffer.sv
design/pcap_replay_uengine.sv
testbench/tb_pcap_replay.sv

//--- design/capture_memory.sv
//**************************************************************************
// Capture memory: one write port, one registered read port
//**************************************************************************

`timescale 1ns/100ps

module capture_memory (
  input  logic                                axi_aclk,
  input  logic                                reset,
  input  logic                                wr_en,
  input  logic [mem_geom_pkg::mem_addr_w-1:0] wr_addr,
  input  logic [stream_pkg::mem_word_w-1:0]   wr_word,
  input  logic                                rd_en,
  input  logic [mem_geom_pkg::mem_addr_w-1:0] rd_addr,
  output logic [stream_pkg::mem_word_w-1:0]   rd_word,
  output logic                                rd_valid
);

  import mem_geom_pkg::*;
  import stream_pkg::*;

  logic [mem_word_w-1:0] mem_array [mem_depth];

  // Inferred block RAM, read data one cycle after the request
  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      mem_array[wr_addr] <= wr_word;
    end
    if (rd_en) begin
      rd_word <= mem_array[rd_addr];
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

endmodule

//--- design/capture_writer.sv
//**************************************************************************
// Capture writer: slave stream into the capture memory, tracks the end
// of the last completed packet
//**************************************************************************

`timescale 1ns/100ps

module capture_writer (
  input  logic                              axi_aclk,
  input  logic                              reset,
  input  logic                              sw_rst,
  input  logic [stream_pkg::data_w-1:0]     s_axis_tdata,
  input  logic                              s_axis_tvalid,
  input  logic                              s_axis_tlast,
  input  logic                              replay_busy,
  output logic                              s_axis_tready,
  output logic                              wr_en,
  output logic [mem_geom_pkg::mem_addr_w-1:0] wr_addr,
  output logic [stream_pkg::mem_word_w-1:0] wr_word,
  output logic [mem_geom_pkg::mem_ptr_w-1:0] capture_end
);

  import mem_geom_pkg::*;

  // Words stored so far, including an unfinished packet
  logic [mem_ptr_w-1:0] fill_ptr;
  logic                 mem_full;
  logic                 accept;

  assign mem_full = (fill_ptr == mem_ptr_w'(mem_depth));

  // No new words while the sequencer is reading the store
  assign s_axis_tready = !mem_full && !replay_busy;
  assign accept        = s_axis_tvalid && s_axis_tready;

  // Write goes straight through on the accepting edge
  assign wr_en   = accept;
  assign wr_addr = fill_ptr[mem_addr_w-1:0];
  assign wr_word = {s_axis_tlast, s_axis_tdata};

  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      fill_ptr    <= '0;
      capture_end <= '0;
    end else if (accept) begin
      fill_ptr <= fill_ptr + mem_ptr_w'(1);
      // Packet boundary moves only on tlast
      if (s_axis_tlast) begin
        capture_end <= fill_ptr + mem_ptr_w'(1);
      end
    end
  end

  // Fill pointer stops at the top of the store
  a_fill_bound: assert property (
    @(posedge axi_aclk) disable iff (reset)
    fill_ptr <= mem_ptr_w'(mem_depth)
  ) else $error("capture fill pointer ran past the memory depth");

endmodule

//--- design/mem_geom_pkg.sv
//**************************************************************************
// Capture memory geometry: depth, address width and fill count width
//**************************************************************************

package mem_geom_pkg;

  // Stream words held in the on-chip capture store
  localparam int mem_depth = 256;

  // Address into the capture store
  localparam int mem_addr_w = $clog2(mem_depth);

  // Fill count has to reach mem_depth itself, hence one extra bit
  localparam int mem_ptr_w = mem_addr_w + 1;

endpackage

//--- design/pcap_replay_uengine.sv
//**************************************************************************
// Packet capture and replay engine top: writer, memory, sequencer and
// output buffer
//**************************************************************************

`timescale 1ns/100ps

module pcap_replay_uengine (
  input  logic                          axi_aclk,
  input  logic                          reset,
  input  logic                          sw_rst,
  input  logic                          replay_start,
  // Slave stream
  input  logic [stream_pkg::data_w-1:0] s_axis_tdata,
  input  logic                          s_axis_tvalid,
  input  logic                          s_axis_tlast,
  output logic                          s_axis_tready,
  // Master stream
  output logic [stream_pkg::data_w-1:0] m_axis_tdata,
  output logic                          m_axis_tvalid,
  output logic                          m_axis_tlast,
  input  logic                          m_axis_tready,
  output logic                          replay_busy
);

  import mem_geom_pkg::*;
  import stream_pkg::*;

  logic                  wr_en;
  logic [mem_addr_w-1:0] wr_addr;
  logic [mem_word_w-1:0] wr_word;
  logic [mem_ptr_w-1:0]  capture_end;
  logic                  rd_en;
  logic [mem_addr_w-1:0] rd_addr;
  logic [mem_word_w-1:0] rd_word;
  logic                  rd_valid;
  logic                  credit_ok;

  capture_writer capture_writer_inst (
    .axi_aclk      (axi_aclk),
    .reset         (reset),
    .sw_rst        (sw_rst),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .replay_busy   (replay_busy),
    .s_axis_tready (s_axis_tready),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_word       (wr_word),
    .capture_end   (capture_end)
  );

  capture_memory capture_memory_inst (
    .axi_aclk (axi_aclk),
    .reset    (reset),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_word  (wr_word),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_word  (rd_word),
    .rd_valid (rd_valid)
  );

  replay_sequencer replay_sequencer_inst (
    .axi_aclk     (axi_aclk),
    .reset        (reset),
    .sw_rst       (sw_rst),
    .replay_start (replay_start),
    .capture_end  (capture_end),
    .credit_ok    (credit_ok),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .replay_busy  (replay_busy)
  );

  replay_out_buffer replay_out_buffer_inst (
    .axi_aclk      (axi_aclk),
    .reset         (reset),
    .sw_rst        (sw_rst),
    .rd_en         (rd_en),
    .rd_valid      (rd_valid),
    .rd_word       (rd_word),
    .m_axis_tready (m_axis_tready),
    .credit_ok     (credit_ok),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid)
  );

endmodule

//--- design/replay_out_buffer.sv
//**************************************************************************
// Replay output buffer: small FIFO with read credit, drives the master
// stream under back-pressure
//**************************************************************************

`timescale 1ns/100ps

module replay_out_buffer (
  input  logic                              axi_aclk,
  input  logic                              reset,
  input  logic                              sw_rst,
  input  logic                              rd_en,
  input  logic                              rd_valid,
  input  logic [stream_pkg::mem_word_w-1:0] rd_word,
  input  logic                              m_axis_tready,
  output logic                              credit_ok,
  output logic [stream_pkg::data_w-1:0]     m_axis_tdata,
  output logic                              m_axis_tlast,
  output logic                              m_axis_tvalid
);

  import stream_pkg::*;

  logic [mem_word_w-1:0] fifo_mem [out_depth];
  logic [out_idx_w-1:0]  wr_idx;
  logic [out_idx_w-1:0]  rd_idx;
  logic [out_cnt_w-1:0]  count;
  logic [out_cnt_w-1:0]  in_flight;
  logic [out_cnt_w:0]    committed;
  // A read issued in the sw_rst cycle still returns one cycle later
  logic                  drop_q;
  logic                  push;
  logic                  pop;

  assign push = rd_valid && !drop_q;
  assign pop  = m_axis_tvalid && m_axis_tready;

  // Stored words, returning reads and the read on the bus this cycle
  assign committed = (out_cnt_w + 1)'(count) + (out_cnt_w + 1)'(in_flight)
                   + (out_cnt_w + 1)'(rd_en);
  assign credit_ok = committed < (out_cnt_w + 1)'(out_depth);

  assign m_axis_tvalid = (count != '0);
  assign {m_axis_tlast, m_axis_tdata} = fifo_mem[rd_idx];

  always_ff @(posedge axi_aclk) begin
    if (push) begin
      fifo_mem[wr_idx] <= rd_word;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      wr_idx    <= '0;
      rd_idx    <= '0;
      count     <= '0;
      in_flight <= '0;
      drop_q    <= sw_rst;
    end else begin
      drop_q <= 1'b0;
      if (push) begin
        wr_idx <= wr_idx + out_idx_w'(1);
      end
      if (pop) begin
        rd_idx <= rd_idx + out_idx_w'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + out_cnt_w'(1);
        2'b01:   count <= count - out_cnt_w'(1);
        default: count <= count;
      endcase
      case ({rd_en, push})
        2'b10:   in_flight <= in_flight + out_cnt_w'(1);
        2'b01:   in_flight <= in_flight - out_cnt_w'(1);
        default: in_flight <= in_flight;
      endcase
    end
  end

  // Credit from the sequencer keeps a returning read from overflowing
  a_no_push_full: assert property (
    @(posedge axi_aclk) disable iff (reset)
    push |-> (count != out_cnt_w'(out_depth))
  ) else $error("output FIFO written while full");

endmodule

//--- design/replay_sequencer.sv
//**************************************************************************
// Replay sequencer: walks the captured addresses under output credit
//**************************************************************************

`timescale 1ns/100ps

module replay_sequencer (
  input  logic                                axi_aclk,
  input  logic                                reset,
  input  logic                                sw_rst,
  input  logic                                replay_start,
  input  logic [mem_geom_pkg::mem_ptr_w-1:0]  capture_end,
  input  logic                                credit_ok,
  output logic                                rd_en,
  output logic [mem_geom_pkg::mem_addr_w-1:0] rd_addr,
  output logic                                replay_busy
);

  import mem_geom_pkg::*;
  import stream_pkg::*;

  seq_state_t           state;
  // Next address to issue and the end latched at start
  logic [mem_ptr_w-1:0] rd_ptr;
  logic [mem_ptr_w-1:0] end_ptr;
  logic [mem_ptr_w-1:0] rd_next;

  assign rd_next     = rd_ptr + mem_ptr_w'(1);
  assign replay_busy = (state == seq_read);

  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      state   <= seq_idle;
      rd_en   <= 1'b0;
      rd_addr <= '0;
      rd_ptr  <= '0;
      end_ptr <= '0;
    end else begin
      rd_en <= 1'b0;
      case (state)
        seq_idle: begin
          // Nothing to play back without a completed packet
          if (replay_start && capture_end != '0) begin
            state   <= seq_read;
            end_ptr <= capture_end;
            rd_ptr  <= '0;
          end
        end
        seq_read: begin
          if (credit_ok) begin
            rd_en   <= 1'b1;
            rd_addr <= rd_ptr[mem_addr_w-1:0];
            rd_ptr  <= rd_next;
            if (rd_next == end_ptr) begin
              state <= seq_idle;
            end
          end
        end
        default: state <= seq_idle;
      endcase
    end
  end

  // Reads stay inside the region completed at start
  a_rd_in_range: assert property (
    @(posedge axi_aclk) disable iff (reset)
    rd_en |-> ({1'b0, rd_addr} < end_ptr)
  ) else $error("replay read address at or beyond the latched end");

endmodule

//--- design/stream_pkg.sv
//**************************************************************************
// Stream word widths, output FIFO sizing and replay sequencer states
//**************************************************************************

package stream_pkg;

  // AXI stream payload
  localparam int data_w = 64;

  // Stored word is tlast on top of tdata
  localparam int mem_word_w = data_w + 1;

  // Output FIFO entries
  localparam int out_depth = 4;
  localparam int out_idx_w = $clog2(out_depth);
  // Occupancy counters must hold out_depth
  localparam int out_cnt_w = $clog2(out_depth + 1);

  // Replay sequencer states
  typedef enum logic [0:0] {
    seq_idle = 1'b0,
    seq_read = 1'b1
  } seq_state_t;

endpackage

//--- testbench/tb_pcap_replay.sv
//**************************************************************************
// Testbench for the capture and replay engine: xorshift stimulus,
// expected word queue, stream and order assertions, closing report
//**************************************************************************

`timescale 1ns/100ps

module tb_pcap_replay;

  import mem_geom_pkg::*;
  import stream_pkg::*;

  logic axi_aclk = 1'b0;
  logic reset;
  logic sw_rst;
  logic replay_start;
  logic [data_w-1:0] s_axis_tdata;
  logic s_axis_tvalid;
  logic s_axis_tlast;
  logic s_axis_tready;
  logic [data_w-1:0] m_axis_tdata;
  logic m_axis_tvalid;
  logic m_axis_tlast;
  logic m_axis_tready;
  logic replay_busy;

  logic [31:0] rng_state = 32'd22;
  // Words of completed packets, in arrival order
  logic [mem_word_w-1:0] exp_q [$];
  logic [mem_word_w-1:0] got_word;
  logic [mem_word_w-1:0] exp_word;
  logic chk_valid;
  logic chk_extra;
  logic last_tlast;
  logic quiet;
  int rep_idx;
  int acc_cnt;
  int errors;
  int timeouts;

  always #20 axi_aclk = ~axi_aclk;

  pcap_replay_uengine uut (
    .axi_aclk      (axi_aclk),
    .reset         (reset),
    .sw_rst        (sw_rst),
    .replay_start  (replay_start),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .replay_busy   (replay_busy)
  );

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Output monitor, one registered check per transferred word
  always @(posedge axi_aclk) begin
    if (reset) begin
      rep_idx    <= 0;
      acc_cnt    <= 0;
      chk_valid  <= 1'b0;
      chk_extra  <= 1'b0;
      last_tlast <= 1'b0;
    end else begin
      chk_valid <= 1'b0;
      if (sw_rst) begin
        acc_cnt <= 0;
      end else if (s_axis_tvalid && s_axis_tready) begin
        acc_cnt <= acc_cnt + 1;
      end
      if (replay_start) begin
        rep_idx <= 0;
      end else if (m_axis_tvalid && m_axis_tready) begin
        chk_valid  <= 1'b1;
        chk_extra  <= (rep_idx >= exp_q.size());
        got_word   <= {m_axis_tlast, m_axis_tdata};
        exp_word   <= (rep_idx < exp_q.size()) ? exp_q[rep_idx] : '0;
        last_tlast <= m_axis_tlast;
        rep_idx    <= rep_idx + 1;
      end
    end
  end

  a_reset_idle: assert property (@(posedge axi_aclk)
    $fell(reset) |-> (!m_axis_tvalid && !replay_busy && s_axis_tready)
  ) else begin
    errors++;
    $display("Mismatch at %0t: %s expected 001 got %b%b%b",
             $time, "m_axis_tvalid,replay_busy,s_axis_tready",
             $sampled(m_axis_tvalid), $sampled(replay_busy), $sampled(s_axis_tready));
  end

  a_no_extra: assert property (@(posedge axi_aclk) disable iff (reset)
    chk_valid |-> !chk_extra
  ) else begin
    errors++;
    $display("Replay sent more words than the completed packets hold at %0t", $time);
  end

  a_out_order: assert property (@(posedge axi_aclk) disable iff (reset)
    (chk_valid && !chk_extra) |-> (got_word == exp_word)
  ) else begin
    errors++;
    $display("Mismatch at %0t: m_axis_tlast,m_axis_tdata expected %h got %h",
             $time, $sampled(exp_word), $sampled(got_word));
  end

  // Stalled word must wait unchanged
  a_hold: assert property (@(posedge axi_aclk) disable iff (reset)
    (m_axis_tvalid && !m_axis_tready) |=>
      (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
  ) else begin
    errors++;
    $display("Master stream word changed or vanished while stalled at %0t", $time);
  end

  a_busy_blocks: assert property (@(posedge axi_aclk) disable iff (reset)
    replay_busy |-> !s_axis_tready
  ) else begin
    errors++;
    $display("Mismatch at %0t: s_axis_tready expected 0 got 1 during replay", $time);
  end

  a_full_blocks: assert property (@(posedge axi_aclk) disable iff (reset)
    (acc_cnt == mem_depth) |-> !s_axis_tready
  ) else begin
    errors++;
    $display("Mismatch at %0t: s_axis_tready expected 0 got 1 with full memory", $time);
  end

  a_room_ready: assert property (@(posedge axi_aclk) disable iff (reset)
    (acc_cnt < mem_depth && !replay_busy) |-> s_axis_tready
  ) else begin
    errors++;
    $display("Mismatch at %0t: s_axis_tready expected 1 got 0", $time);
  end

  a_quiet: assert property (@(posedge axi_aclk) disable iff (reset)
    quiet |-> (!m_axis_tvalid && !replay_busy)
  ) else begin
    errors++;
    $display("Mismatch at %0t: m_axis_tvalid expected 0 got %b after sw_rst",
             $time, $sampled(m_axis_tvalid));
  end

  // Packets without tlast stay out of the expected queue
  task automatic send_packet(input int len, input bit complete);
    logic [mem_word_w-1:0] pkt [$];
    logic last;
    int cycles;
    for (int i = 0; i < len; i++) begin
      last          = complete && (i == len - 1);
      s_axis_tdata  = {next_rand(), next_rand()};
      s_axis_tlast  = last;
      s_axis_tvalid = 1'b1;
      cycles        = 0;
      while (!s_axis_tready && cycles < 500) begin
        @(posedge axi_aclk);
        #2;
        cycles++;
      end
      if (cycles >= 500) begin
        timeouts++;
        $display("Timeout at %0t: s_axis_tready stayed low", $time);
        break;
      end
      pkt.push_back({last, s_axis_tdata});
      @(posedge axi_aclk);
      #2;
    end
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    if (complete) begin
      foreach (pkt[k]) begin
        exp_q.push_back(pkt[k]);
      end
    end
  endtask

  task automatic run_replay(input bit stall);
    logic [31:0] r;
    int cycles;
    replay_start = 1'b1;
    @(posedge axi_aclk);
    #2;
    replay_start = 1'b0;
    cycles       = 0;
    while ((rep_idx < exp_q.size() || replay_busy || m_axis_tvalid) && cycles < 2000) begin
      r             = next_rand();
      m_axis_tready = stall ? r[0] : 1'b1;
      @(posedge axi_aclk);
      #2;
      cycles++;
    end
    m_axis_tready = 1'b1;
    if (cycles >= 2000) begin
      timeouts++;
      $display("Timeout at %0t: replay did not drain", $time);
    end
  endtask

  task automatic pulse_sw_rst();
    sw_rst = 1'b1;
    @(posedge axi_aclk);
    #2;
    sw_rst = 1'b0;
    exp_q.delete();
  endtask

  initial begin
    reset         = 1'b1;
    sw_rst        = 1'b0;
    replay_start  = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b1;
    quiet         = 1'b0;
    errors        = 0;
    timeouts      = 0;
    repeat (3) @(posedge axi_aclk);
    #2;
    reset = 1'b0;

    for (int p = 0; p < 3; p++) begin
      send_packet(1 + int'(next_rand() % 12), 1'b1);
    end
    run_replay(1'b0);
    run_replay(1'b0);
    // Same capture under random back-pressure
    run_replay(1'b1);

    // Trailing packet never closed
    send_packet(5, 1'b0);
    run_replay(1'b0);
    a_last_tlast: assert (last_tlast) else begin
      errors++;
      $display("Mismatch at %0t: m_axis_tlast of last word expected 1 got 0", $time);
    end

    pulse_sw_rst();
    quiet = 1'b1;
    run_replay(1'b0);
    repeat (20) @(posedge axi_aclk);
    #2;
    quiet = 1'b0;

    // Fill the whole store, then play it back
    send_packet(mem_depth, 1'b1);
    run_replay(1'b1);
    repeat (4) @(posedge axi_aclk);

    $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
